// File: source/string_pkg.sv
package string_pkg;

	// word and address widths of the voice.
	localparam int sample_w = 32;
	localparam int ptr_w = 10; // 1024-word delay RAM.

	// shortest string the loop can hold.
	localparam int min_length = 4;

	localparam logic [sample_w-1:0] noise_seed = 32'h1d87_2b41; // xorshift start value.

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic [ptr_w-1:0] length_t;

	// excitation phase.
	typedef enum logic {
		burst_idle,
		burst_active
	} burst_state_e;

	// one sample leaving the voice.
	typedef struct packed {
		logic valid;
		sample_t data;
		logic in_burst; // written by a noise step.
	} voice_sample_t;

endpackage

// File: source/pluck_debounce.sv
`timescale 1ns/1ps

module pluck_debounce #(
	parameter int debounce_cycles = 8
) (
	input logic clk,
	input logic trig_reset,
	input logic trig,
	output logic pluck
);

	localparam int cnt_w = $clog2(debounce_cycles + 1);

	logic [1:0] sync_q; // two-flop synchronizer.
	logic level_q; // debounced button level.
	logic [cnt_w-1:0] cnt_q;

	// the level only flips after debounce_cycles of a steady new value.
	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			sync_q <= '0;
			level_q <= 1'b0;
			cnt_q <= '0;
			pluck <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], trig};
			pluck <= 1'b0;
			if (sync_q[1] == level_q)
			begin
				cnt_q <= '0; // bounce back, start over.
			end
			else if (cnt_q == cnt_w'(debounce_cycles - 1))
			begin
				level_q <= sync_q[1];
				cnt_q <= '0;
				pluck <= sync_q[1]; // rising level only.
			end
			else
			begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

endmodule

// File: source/excitation_control.sv
`timescale 1ns/1ps

module excitation_control (
	input logic clk,
	input logic trig_reset,
	input logic pluck,
	input logic step,
	input string_pkg::length_t string_length,
	input string_pkg::sample_t feedback,
	output string_pkg::sample_t line_in,
	output string_pkg::length_t length,
	output logic restart,
	output logic in_burst
);
	import string_pkg::*;

	logic pending_q; // pluck waiting for a step.
	length_t len_q;
	burst_state_e state_q;
	logic [ptr_w:0] burst_cnt_q; // counts up to 2L.
	logic [ptr_w:0] burst_last;
	logic [sample_w-1:0] noise_q;
	logic burst_step;

	// xorshift32 with shifts 13, 17, 5.
	function automatic logic [sample_w-1:0] xorshift32(input logic [sample_w-1:0] x);
		logic [sample_w-1:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign burst_last = {len_q, 1'b0} - 1'b1;
	assign in_burst = pending_q || (state_q == burst_active); // restart step is burst step 0.
	assign burst_step = step && in_burst;
	assign restart = pending_q;
	assign length = len_q;
	assign line_in = in_burst ? sample_t'(noise_q) : feedback;

	// pluck latches the clamped length and stays pending until the next step.
	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			pending_q <= 1'b0;
			len_q <= length_t'(min_length);
		end
		else if (pluck)
		begin
			pending_q <= 1'b1;
			len_q <= (string_length < length_t'(min_length)) ? length_t'(min_length)
				: string_length;
		end
		else if (step)
		begin
			pending_q <= 1'b0;
		end
	end

	// burst of 2L noise words, noise only moves on burst steps.
	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			state_q <= burst_idle;
			burst_cnt_q <= '0;
			noise_q <= noise_seed;
		end
		else if (burst_step)
		begin
			noise_q <= xorshift32(noise_q);
			if (pending_q)
			begin
				state_q <= burst_active;
				burst_cnt_q <= (ptr_w + 1)'(1); // this step is number 0.
			end
			else if (burst_cnt_q == burst_last)
			begin
				state_q <= burst_idle;
			end
			else
			begin
				burst_cnt_q <= burst_cnt_q + 1'b1;
			end
		end
	end

endmodule

// File: source/delay_line.sv
`timescale 1ns/1ps

module delay_line (
	input logic clk,
	input logic trig_reset,
	input logic step,
	input logic restart,
	input string_pkg::length_t length,
	input string_pkg::sample_t line_in,
	output string_pkg::sample_t line_out,
	output logic clearing
);
	import string_pkg::*;

	sample_t ram [0:(1 << ptr_w) - 1];

	length_t ptr_q;
	length_t addr;
	length_t ptr_next;
	logic [ptr_w-1:0] clear_ptr_q;
	logic clearing_q;
	logic wr_en;
	logic [ptr_w-1:0] wr_addr;
	sample_t wr_data;

	// restart step reads and writes address 0.
	assign addr = restart ? '0 : ptr_q;
	assign ptr_next = (addr >= length - 1'b1) ? '0 : addr + 1'b1;

	// old word out before the write lands.
	assign line_out = ram[addr];
	assign clearing = clearing_q;

	// sweep of zeros shares the single write port.
	assign wr_en = clearing_q || step;
	assign wr_addr = clearing_q ? clear_ptr_q : addr;
	assign wr_data = clearing_q ? '0 : line_in;

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			clearing_q <= 1'b1;
			clear_ptr_q <= '0;
			ptr_q <= '0;
		end
		else if (clearing_q)
		begin
			clear_ptr_q <= clear_ptr_q + 1'b1;
			if (&clear_ptr_q)
				clearing_q <= 1'b0; // last address written.
		end
		else if (step)
		begin
			ptr_q <= ptr_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
	end

endmodule

// File: source/loop_filter.sv
`timescale 1ns/1ps

module loop_filter (
	input logic clk,
	input logic trig_reset,
	input logic step,
	input string_pkg::sample_t line_out,
	output string_pkg::sample_t feedback
);
	import string_pkg::*;

	sample_t prev_q; // line_out of the last step.
	logic signed [sample_w:0] sum;

	// 33-bit sum so the average cannot overflow.
	assign sum = $signed({line_out[sample_w-1], line_out})
		+ $signed({prev_q[sample_w-1], prev_q});

	// arithmetic shift by one, top bit is only sign.
	assign feedback = sample_t'(sum[sample_w:1]);

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
		begin
			prev_q <= '0;
		end
		else if (step)
		begin
			prev_q <= line_out;
		end
	end

endmodule

// File: source/credit_port.sv
`timescale 1ns/1ps

module credit_port #(
	parameter int max_credits = 4
) (
	input logic clk,
	input logic trig_reset,
	input logic credit_return,
	input logic clearing,
	input logic in_burst,
	input string_pkg::sample_t line_out,
	output logic step,
	output string_pkg::voice_sample_t sample_out
);
	import string_pkg::*;

	localparam int cnt_w = $clog2(max_credits + 1);

	logic [cnt_w-1:0] count_q;
	logic accept;
	logic valid_q;
	logic burst_q;
	sample_t data_q;

	// one credit spent per step, none while the RAM is swept.
	assign step = (count_q != '0) && !clearing;
	assign accept = credit_return && ((count_q != cnt_w'(max_credits)) || step); // full drops.

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
			count_q <= '0;
		else if (clearing)
			count_q <= '0;
		else
			count_q <= count_q + cnt_w'(accept) - cnt_w'(step);
	end

	always_ff @(posedge clk)
	begin
		if (!trig_reset)
			valid_q <= 1'b0;
		else
			valid_q <= step;
	end

	// the word read on the step, one cycle later.
	always_ff @(posedge clk)
	begin
		if (step)
		begin
			data_q <= line_out;
			burst_q <= in_burst;
		end
	end

	assign sample_out = '{valid: valid_q, data: data_q, in_burst: burst_q};

endmodule

// File: source/string_voice.sv
`timescale 1ns/1ps

module string_voice #(
	parameter int debounce_cycles = 8,
	parameter int max_credits = 4
) (
	input logic clk,
	input logic trig_reset,
	input logic trig,
	input string_pkg::length_t string_length,
	input logic credit_return,
	output string_pkg::voice_sample_t sample_out
);
	import string_pkg::*;

	logic pluck;
	logic step;
	logic restart;
	logic in_burst;
	logic clearing;
	length_t length;
	sample_t line_in;
	sample_t line_out;
	sample_t feedback;

	pluck_debounce #(.debounce_cycles(debounce_cycles)) pluck_debounce_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.trig(trig),
		.pluck(pluck)
	);

	excitation_control excitation_control_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.pluck(pluck),
		.step(step),
		.string_length(string_length),
		.feedback(feedback),
		.line_in(line_in),
		.length(length),
		.restart(restart),
		.in_burst(in_burst)
	);

	delay_line delay_line_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.step(step),
		.restart(restart),
		.length(length),
		.line_in(line_in),
		.line_out(line_out),
		.clearing(clearing)
	);

	// closes the string loop back into excitation_control.
	loop_filter loop_filter_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.step(step),
		.line_out(line_out),
		.feedback(feedback)
	);

	credit_port #(.max_credits(max_credits)) credit_port_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.credit_return(credit_return),
		.clearing(clearing),
		.in_burst(in_burst),
		.line_out(line_out),
		.step(step),
		.sample_out(sample_out)
	);

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 100
) (
	output logic clk
);

	initial
		clk = 1'b0;

	always #(period_ns / 2) clk = ~clk; // 50 ns high, 50 ns low.

endmodule

// File: tb/string_voice_props.sv
`timescale 1ns/1ps

module string_voice_props #(
	parameter int max_credits = 4
) (
	input logic clk,
	input logic trig_reset,
	input logic clearing,
	input logic step,
	input logic [$clog2(max_credits + 1)-1:0] count,
	input string_pkg::voice_sample_t sample_out
);

	int failures = 0; // failed properties so far.

	no_step_while_clearing: assert property (@(posedge clk) disable iff (!trig_reset)
		clearing |-> !step)
	else
	begin
		$error("step raised during the RAM clear sweep");
		failures++;
	end

	credits_bounded: assert property (@(posedge clk) disable iff (!trig_reset)
		count <= max_credits)
	else
	begin
		$error("credit count above capacity");
		failures++;
	end

	// every step shows up at the output one cycle later.
	step_gives_sample: assert property (@(posedge clk) disable iff (!trig_reset)
		step |=> sample_out.valid)
	else
	begin
		$error("step without a valid sample one cycle later");
		failures++;
	end

endmodule

bind credit_port string_voice_props #(.max_credits(max_credits)) props_i (
	.clk(clk),
	.trig_reset(trig_reset),
	.clearing(clearing),
	.step(step),
	.count(count_q),
	.sample_out(sample_out)
);

// File: tb/string_voice_tb.sv
`timescale 1ns/1ps

module string_voice_tb;
	import string_pkg::*;

	localparam int debounce_cycles = 8;
	localparam int max_credits = 4;
	// reset and clear, then each test, at about four cycles per credit.
	localparam int test_cycles = 16 + 1100 + 200 + 3 * (20 + 24) + 4 + 24
		+ 4 * (12 + 100 + 40 + 30 + 60 * 4) + 60 * 15;

	logic clk;
	logic trig_reset;
	logic trig;
	length_t string_length;
	logic credit_return;
	voice_sample_t sample_out;

	sample_t m_ram [0:(1 << ptr_w) - 1]; // reference string.
	length_t m_ptr;
	length_t m_len;
	int m_burst_cnt;
	logic [31:0] m_noise;
	sample_t m_prev;
	logic m_restart; // pluck waiting for its step.

	int credits_sent;
	int samples_seen;
	int burst_seen;
	logic [31:0] rnd;

	tb_clock #(.period_ns(100)) tb_clock_i (.clk(clk));

	string_voice #(
		.debounce_cycles(debounce_cycles),
		.max_credits(max_credits)
	) string_voice_i (
		.clk(clk),
		.trig_reset(trig_reset),
		.trig(trig),
		.string_length(string_length),
		.credit_return(credit_return),
		.sample_out(sample_out)
	);

	// xorshift32, shifts 13, 17, 5.
	function automatic logic [31:0] xorshift_next(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic model_reset();
		for (int i = 0; i < (1 << ptr_w); i++)
			m_ram[i] = '0;
		m_ptr = '0;
		m_len = length_t'(min_length);
		m_burst_cnt = 2 * min_length; // no burst before the first pluck.
		m_noise = noise_seed;
		m_prev = '0;
		m_restart = 1'b0;
	endtask

	task automatic model_pluck(input int len);
		m_len = (len < min_length) ? length_t'(min_length) : length_t'(len);
		m_restart = 1'b1;
	endtask

	// one string step: read old word, write noise or average, advance.
	task automatic model_step(output sample_t exp_data, output logic exp_burst);
		logic [sample_w:0] sum;
		if (m_restart)
		begin
			m_ptr = '0;
			m_burst_cnt = 0;
			m_restart = 1'b0;
		end
		exp_data = m_ram[m_ptr];
		exp_burst = (m_burst_cnt < 2 * int'(m_len));
		sum = {exp_data[sample_w-1], exp_data} + {m_prev[sample_w-1], m_prev};
		if (exp_burst)
		begin
			m_ram[m_ptr] = m_noise;
			m_noise = xorshift_next(m_noise);
			m_burst_cnt++;
		end
		else
			m_ram[m_ptr] = sum[sample_w:1];
		m_prev = exp_data;
		m_ptr = (int'(m_ptr) + 1 >= int'(m_len)) ? '0 : m_ptr + 1'b1;
	endtask

	task automatic check_sample();
		sample_t exp_data;
		logic exp_burst;
		assert (samples_seen < credits_sent)
		else
		begin
			$display("valid sample at %0t without a returned credit", $time);
			abort_run();
		end
		model_step(exp_data, exp_burst);
		assert (sample_out.data == exp_data)
		else report_mismatch("sample_out.data", exp_data, sample_out.data);
		assert (sample_out.in_burst == exp_burst)
		else report_mismatch("sample_out.in_burst", 32'(exp_burst), 32'(sample_out.in_burst));
		samples_seen++;
		if (sample_out.in_burst)
			burst_seen++;
	endtask

	// outputs are registered, so mid-cycle is stable.
	always @(negedge clk)
	begin
		assert (string_voice_i.credit_port_i.props_i.failures == 0)
		else
		begin
			$display("a credit_port property failed");
			abort_run();
		end
		if (trig_reset && sample_out.valid)
			check_sample();
	end

	// one credit pulse, held back while the sink is full.
	task automatic send_credit();
		@(posedge clk);
		while (credits_sent - samples_seen >= max_credits)
			@(posedge clk);
		@(negedge clk);
		credit_return = 1'b1;
		credits_sent++;
		@(negedge clk);
		credit_return = 1'b0;
	endtask

	task automatic wait_drained();
		int waited = 0;
		@(posedge clk);
		while (samples_seen != credits_sent && waited < 50)
		begin
			@(posedge clk);
			waited++;
		end
		assert (samples_seen == credits_sent)
		else report_mismatch("valid count", 32'(credits_sent), 32'(samples_seen));
		@(negedge clk);
	endtask

	task automatic run_steps(input int n);
		repeat (n)
			send_credit();
		wait_drained();
	endtask

	task automatic press_trig(input int hold);
		@(negedge clk);
		trig = 1'b1;
		repeat (hold) @(negedge clk);
		trig = 1'b0;
		repeat (3 * debounce_cycles) @(negedge clk); // debouncer rearms.
	endtask

	task automatic check_burst_len(input int expected);
		assert (burst_seen == expected)
		else report_mismatch("burst sample count", 32'(expected), 32'(burst_seen));
	endtask

	task automatic silence_after_reset();
		repeat (200) @(negedge clk);
		assert (samples_seen == 0)
		else report_mismatch("valid count", 32'd0, 32'(samples_seen));
		run_steps(12);
	endtask

	task automatic pluck_long_string();
		string_length = 10'd20;
		press_trig(20);
		model_pluck(20);
		burst_seen = 0;
		run_steps(100);
		check_burst_len(40);
	endtask

	task automatic glitch_ignored();
		press_trig(debounce_cycles / 2);
		burst_seen = 0;
		run_steps(40);
		check_burst_len(0);
	endtask

	task automatic length_clamped();
		string_length = 10'd2;
		press_trig(20);
		model_pluck(2);
		burst_seen = 0;
		run_steps(30);
		check_burst_len(8);
	endtask

	task automatic random_backpressure();
		repeat (60)
		begin
			rnd = xorshift_next(rnd);
			repeat (int'(rnd[1:0]) + 1)
				send_credit();
			repeat (int'(rnd[7:4])) @(negedge clk);
		end
		wait_drained();
	endtask

	initial
	begin
		repeat (test_cycles * 3 / 2) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish",
			test_cycles * 3 / 2);
		abort_run();
	end

	initial
	begin
		trig_reset = 1'b0;
		trig = 1'b0;
		string_length = '0;
		credit_return = 1'b0;
		credits_sent = 0;
		samples_seen = 0;
		burst_seen = 0;
		rnd = 32'h7fb0_0d90;
		model_reset();
		repeat (16) @(negedge clk);
		trig_reset = 1'b1;
		repeat (1100) @(negedge clk); // RAM clear sweep.
		silence_after_reset();
		pluck_long_string();
		glitch_ignored();
		length_clamped();
		random_backpressure();
		if (samples_seen == credits_sent)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			abort_run();
		end
	end

endmodule

// File: verilog.f
source/string_pkg.sv
source/pluck_debounce.sv
source/excitation_control.sv
source/delay_line.sv
source/loop_filter.sv
source/credit_port.sv
source/string_voice.sv
tb/tb_clock.sv
tb/string_voice_props.sv
tb/string_voice_tb.sv

// File: Makefile
SIM      := verilator
TOP      := string_voice_tb
FILELIST := verilog.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
